//--- rtl/draw_pkg.sv
// ################################################
// draw package: coordinate widths, credit depths,
// command opcodes and the command, job and pixel types
// ################################################
package draw_pkg;

    localparam int CORDW       = 16;  // signed coordinate width
    localparam int TAGW        = 4;   // command tag width
    localparam int COLW        = 8;   // colour width
    localparam int CMD_CREDITS = 2;   // command queue depth
    localparam int PIX_CREDITS = 4;   // downstream pixel slots

    typedef enum logic [0:0] {
        OP_LINE = 1'b0,  // line v0 to v1
        OP_TRI  = 1'b1   // triangle outline v0 v1 v2
    } draw_op_e;

    typedef struct packed {
        draw_op_e                op;
        logic [TAGW-1:0]         tag;
        logic [COLW-1:0]         colour;
        logic signed [CORDW-1:0] x0, y0;  // vertex 0
        logic signed [CORDW-1:0] x1, y1;  // vertex 1
        logic signed [CORDW-1:0] x2, y2;  // vertex 2, unused by lines
    } draw_cmd_t;

    typedef struct packed {
        logic signed [CORDW-1:0] x0, y0;
        logic signed [CORDW-1:0] x1, y1;
        logic signed [CORDW-1:0] x2, y2;
        logic [COLW-1:0]         colour;
        logic [TAGW-1:0]         tag;
    } draw_job_t;

    typedef struct packed {
        logic signed [CORDW-1:0] x;
        logic signed [CORDW-1:0] y;
        logic [COLW-1:0]         colour;
        logic [TAGW-1:0]         tag;
        logic                    last;  // final pixel of its command
    } pixel_t;

endpackage

//--- rtl/draw_line.sv
// ################################################
// Bresenham line drawer, one pixel per enabled cycle
// between two signed points, all octants
// ################################################
`timescale 1ns/1ns

module draw_line (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                start,    // latch end points
    input  logic                                oe,       // advance one pixel
    input  logic signed [draw_pkg::CORDW-1:0]   x0,
    input  logic signed [draw_pkg::CORDW-1:0]   y0,
    input  logic signed [draw_pkg::CORDW-1:0]   x1,
    input  logic signed [draw_pkg::CORDW-1:0]   y1,
    output logic signed [draw_pkg::CORDW-1:0]   x,
    output logic signed [draw_pkg::CORDW-1:0]   y,
    output logic                                drawing,
    output logic                                last,     // pixel at end point
    output logic                                done      // one cycle pulse
);
    import draw_pkg::*;

    typedef enum logic [1:0] {IDLE, INIT, DRAW} state_e;

    state_e                  state;
    logic signed [CORDW-1:0] xe, ye;            // end point
    logic signed [CORDW+1:0] dx_in, dy_in;      // raw deltas, widened
    logic signed [CORDW+1:0] dx, dy;            // |dx| and -|dy|
    logic signed [CORDW+1:0] err, err_cur, err_nxt, e2;
    logic                    sx, sy;            // 1 = step negative
    logic                    step_x, step_y;

    assign dx_in = (CORDW+2)'(x1) - (CORDW+2)'(x0);  // sign extended
    assign dy_in = (CORDW+2)'(y1) - (CORDW+2)'(y0);

    // error term only settles in init, first pixel goes out meanwhile
    assign err_cur = (state == INIT) ? dx + dy : err;
    assign e2      = err_cur <<< 1;
    assign step_x  = (e2 >= dy);
    assign step_y  = (e2 <= dx);

    always_comb begin
        err_nxt = err_cur;
        if (step_x) err_nxt = err_nxt + dy;
        if (step_y) err_nxt = err_nxt + dx;
    end

    assign drawing = (state != IDLE);
    assign last    = drawing && (x == xe) && (y == ye);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                IDLE: if (start) state <= INIT;
                default: begin  // init or draw
                    if (oe && last) begin
                        state <= IDLE;
                        done  <= 1'b1;  // cycle after final pixel
                    end else if (oe) begin
                        state <= DRAW;
                    end
                end
            endcase
        end
    end

    // datapath
    always_ff @(posedge clk) begin
        if (state == IDLE && start) begin
            x  <= x0;
            y  <= y0;
            xe <= x1;
            ye <= y1;
            sx <= dx_in[CORDW+1];
            sy <= dy_in[CORDW+1];
            dx <= dx_in[CORDW+1] ? -dx_in : dx_in;
            dy <= dy_in[CORDW+1] ? dy_in : -dy_in;
        end else if (drawing && oe && !last) begin
            err <= err_nxt;
            if (step_x) x <= sx ? x - 1'b1 : x + 1'b1;
            if (step_y) y <= sy ? y - 1'b1 : y + 1'b1;
        end
    end

    drawing_needs_start: assert property (
        @(posedge clk) disable iff (rst) $rose(drawing) |-> $past(start)
    );

endmodule

//--- rtl/draw_triangle.sv
// ################################################
// triangle outline engine, walks edges v0-v1, v1-v2
// and v2-v0 through one line drawer
// ################################################
`timescale 1ns/1ns

module draw_triangle (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                start,
    input  logic                                oe,
    input  draw_pkg::draw_job_t                 job,
    output logic signed [draw_pkg::CORDW-1:0]   x,
    output logic signed [draw_pkg::CORDW-1:0]   y,
    output logic                                drawing,
    output logic                                last,    // end of third edge
    output logic                                done,
    output logic                                busy,
    output logic [draw_pkg::TAGW-1:0]           tag,
    output logic [draw_pkg::COLW-1:0]           colour
);
    import draw_pkg::*;

    typedef enum logic [1:0] {IDLE, INIT, DRAW} state_e;

    state_e                  state;
    draw_job_t               jreg;            // job held for all edges
    logic [1:0]              edge_id;         // 0, 1 or 2
    logic                    line_start;
    logic                    line_last;
    logic                    line_done;
    logic signed [CORDW-1:0] lx0, ly0, lx1, ly1;  // current edge

    assign tag    = jreg.tag;
    assign colour = jreg.colour;
    assign last   = line_last && (edge_id == 2'd2);

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= IDLE;
            edge_id    <= 2'd0;
            line_start <= 1'b0;
            done       <= 1'b0;
            busy       <= 1'b0;
        end else begin
            line_start <= 1'b0;
            done       <= 1'b0;
            case (state)
                INIT: begin
                    line_start <= 1'b1;  // edge latched this cycle
                    state      <= DRAW;
                end
                DRAW: begin
                    if (line_done && edge_id == 2'd2) begin
                        done  <= 1'b1;
                        busy  <= 1'b0;
                        state <= IDLE;
                    end else if (line_done) begin
                        edge_id <= edge_id + 2'd1;
                        state   <= INIT;
                    end
                end
                default: begin
                    if (start) begin
                        edge_id <= 2'd0;
                        busy    <= 1'b1;
                        state   <= INIT;
                    end
                end
            endcase
        end
    end

    // job and edge end points
    always_ff @(posedge clk) begin
        if (state == IDLE && start) jreg <= job;
        if (state == INIT) begin
            case (edge_id)
                2'd0: begin
                    lx0 <= jreg.x0;
                    ly0 <= jreg.y0;
                    lx1 <= jreg.x1;
                    ly1 <= jreg.y1;
                end
                2'd1: begin
                    lx0 <= jreg.x1;
                    ly0 <= jreg.y1;
                    lx1 <= jreg.x2;
                    ly1 <= jreg.y2;
                end
                default: begin  // closing edge
                    lx0 <= jreg.x2;
                    ly0 <= jreg.y2;
                    lx1 <= jreg.x0;
                    ly1 <= jreg.y0;
                end
            endcase
        end
    end

    draw_line u_line (
        .clk     (clk),
        .rst     (rst),
        .start   (line_start),
        .oe      (oe),
        .x0      (lx0),
        .y0      (ly0),
        .x1      (lx1),
        .y1      (ly1),
        .x       (x),
        .y       (y),
        .drawing (drawing),
        .last    (line_last),
        .done    (line_done)
    );

    edge_in_range: assert property (
        @(posedge clk) disable iff (rst) edge_id <= 2'd2
    );

endmodule

//--- rtl/cmd_dispatch.sv
// ################################################
// command queue with credit return, issues the head
// command to the idle engine matching its opcode
// ################################################
`timescale 1ns/1ns

module cmd_dispatch (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          cmd_valid,
    input  draw_pkg::draw_cmd_t           cmd,
    output logic                          cmd_credit,   // entry left the queue
    input  logic                          line_busy,
    input  logic                          tri_busy,
    output logic                          line_start,
    output logic                          tri_start,
    output draw_pkg::draw_job_t           job,          // shared, valid with start
    output logic [draw_pkg::TAGW-1:0]     line_tag,     // held for the line engine
    output logic [draw_pkg::COLW-1:0]     line_colour
);
    import draw_pkg::*;

    draw_cmd_t                       q [CMD_CREDITS];
    logic [$clog2(CMD_CREDITS)-1:0]  wr_ptr, rd_ptr;
    logic [$clog2(CMD_CREDITS):0]    count;
    draw_cmd_t                       head;
    logic                            issue;

    assign head = q[rd_ptr];

    // head goes only to an engine neither busy nor just started
    always_comb begin
        case (head.op)
            OP_LINE: issue = (count != '0) && !line_busy && !line_start;
            default: issue = (count != '0) && !tri_busy && !tri_start;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            cmd_credit <= 1'b0;
            line_start <= 1'b0;
            tri_start  <= 1'b0;
        end else begin
            if (cmd_valid) wr_ptr <= wr_ptr + 1'b1;
            if (issue) rd_ptr <= rd_ptr + 1'b1;
            count      <= count + cmd_valid - issue;
            cmd_credit <= issue;
            line_start <= issue && (head.op == OP_LINE);
            tri_start  <= issue && (head.op == OP_TRI);
        end
    end

    always_ff @(posedge clk) begin
        if (cmd_valid) q[wr_ptr] <= cmd;
        if (issue) begin
            job <= '{x0: head.x0, y0: head.y0, x1: head.x1, y1: head.y1,
                     x2: head.x2, y2: head.y2, colour: head.colour, tag: head.tag};
        end
        if (issue && head.op == OP_LINE) begin
            line_tag    <= head.tag;
            line_colour <= head.colour;
        end
    end

    no_cmd_overflow: assert property (
        @(posedge clk) disable iff (rst) !(cmd_valid && count == CMD_CREDITS)
    );

endmodule

//--- rtl/pixel_merge.sv
// ################################################
// round-robin merge of line and triangle pixels into
// one registered, credit-controlled output
// ################################################
`timescale 1ns/1ns

module pixel_merge (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                line_drawing,
    input  logic signed [draw_pkg::CORDW-1:0]   line_x,
    input  logic signed [draw_pkg::CORDW-1:0]   line_y,
    input  logic                                line_last,
    input  logic [draw_pkg::TAGW-1:0]           line_tag,
    input  logic [draw_pkg::COLW-1:0]           line_colour,
    input  logic                                tri_drawing,
    input  logic signed [draw_pkg::CORDW-1:0]   tri_x,
    input  logic signed [draw_pkg::CORDW-1:0]   tri_y,
    input  logic                                tri_last,
    input  logic [draw_pkg::TAGW-1:0]           tri_tag,
    input  logic [draw_pkg::COLW-1:0]           tri_colour,
    output logic                                line_oe,
    output logic                                tri_oe,
    output logic                                pix_valid,
    output draw_pkg::pixel_t                    pix,
    input  logic                                pix_credit
);
    import draw_pkg::*;

    logic [$clog2(PIX_CREDITS+1)-1:0] credits;  // free downstream slots
    logic                             credit_ok;
    logic                             prefer_tri;  // round-robin pointer

    // pixel already in pix holds a credit not yet taken off the counter
    assign credit_ok = credits > $bits(credits)'(pix_valid);

    assign line_oe = credit_ok && line_drawing && !(tri_drawing && prefer_tri);
    assign tri_oe  = credit_ok && tri_drawing && !(line_drawing && !prefer_tri);

    always_ff @(posedge clk) begin
        if (rst) begin
            credits    <= $bits(credits)'(PIX_CREDITS);
            prefer_tri <= 1'b0;
            pix_valid  <= 1'b0;
        end else begin
            credits   <= credits - pix_valid + pix_credit;
            pix_valid <= line_oe || tri_oe;
            if (line_oe) prefer_tri <= 1'b1;  // other side next
            else if (tri_oe) prefer_tri <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (line_oe) begin
            pix <= '{x: line_x, y: line_y, colour: line_colour,
                     tag: line_tag, last: line_last};
        end else if (tri_oe) begin
            pix <= '{x: tri_x, y: tri_y, colour: tri_colour,
                     tag: tri_tag, last: tri_last};
        end
    end

    credit_bounds: assert property (
        @(posedge clk) disable iff (rst)
        (credits <= PIX_CREDITS) && !(pix_valid && credits == '0)
    );

    one_grant: assert property (
        @(posedge clk) disable iff (rst) !(line_oe && tri_oe)
    );

endmodule

//--- rtl/draw_top.sv
// ################################################
// outline rasterizer top: dispatcher, line and
// triangle engines, pixel merger
// ################################################
`timescale 1ns/1ns

module draw_top (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  cmd_valid,
    input  draw_pkg::draw_cmd_t   cmd,
    output logic                  cmd_credit,
    output logic                  pix_valid,
    output draw_pkg::pixel_t      pix,
    input  logic                  pix_credit
);
    import draw_pkg::*;

    draw_job_t               job;
    logic                    line_start, tri_start;
    logic                    line_oe, tri_oe;
    logic                    line_drawing, tri_drawing, tri_busy;
    logic                    line_last, tri_last;
    logic signed [CORDW-1:0] line_x, line_y, tri_x, tri_y;
    logic [TAGW-1:0]         line_tag, tri_tag;
    logic [COLW-1:0]         line_colour, tri_colour;

    cmd_dispatch u_dispatch (
        .clk (clk), .rst (rst),
        .cmd_valid (cmd_valid), .cmd (cmd), .cmd_credit (cmd_credit),
        .line_busy (line_drawing),  // line drawer busy while drawing
        .tri_busy (tri_busy),
        .line_start (line_start), .tri_start (tri_start), .job (job),
        .line_tag (line_tag), .line_colour (line_colour)
    );

    draw_line u_line (
        .clk (clk), .rst (rst), .start (line_start), .oe (line_oe),
        .x0 (job.x0), .y0 (job.y0), .x1 (job.x1), .y1 (job.y1),
        .x (line_x), .y (line_y), .drawing (line_drawing),
        .last (line_last), .done ()
    );

    draw_triangle u_tri (
        .clk (clk), .rst (rst), .start (tri_start), .oe (tri_oe), .job (job),
        .x (tri_x), .y (tri_y), .drawing (tri_drawing), .last (tri_last),
        .done (), .busy (tri_busy), .tag (tri_tag), .colour (tri_colour)
    );

    pixel_merge u_merge (
        .clk (clk), .rst (rst),
        .line_drawing (line_drawing), .line_x (line_x), .line_y (line_y),
        .line_last (line_last), .line_tag (line_tag), .line_colour (line_colour),
        .tri_drawing (tri_drawing), .tri_x (tri_x), .tri_y (tri_y),
        .tri_last (tri_last), .tri_tag (tri_tag), .tri_colour (tri_colour),
        .line_oe (line_oe), .tri_oe (tri_oe),
        .pix_valid (pix_valid), .pix (pix), .pix_credit (pix_credit)
    );

endmodule

//--- testbench/draw_checker.sv
// ################################################
// rasterizer checker: Bresenham model per tag, pixel
// compare, command and pixel credit rules
// ################################################
`timescale 1ns/1ns

module draw_checker (
    input  logic                clk,
    input  logic                rst,
    input  logic                cmd_valid,
    input  draw_pkg::draw_cmd_t cmd,
    input  logic                cmd_credit,
    input  logic                pix_valid,
    input  draw_pkg::pixel_t    pix,
    input  logic                pix_credit,
    input  logic                drain,
    output int                  mismatches,
    output int                  errors,
    output int                  cmds_open
);
    import draw_pkg::*;

    pixel_t exp_q [16][$];           // expected pixels per tag
    int     spent, returned;         // command credits
    int     outstanding;             // pixels held downstream
    logic   rst_d, rst_d2;
    logic   drained = 1'b0;

    function automatic int coord(input logic signed [CORDW-1:0] v);
        return int'(v);  // sign extend
    endfunction

    // reference Bresenham, both end points included
    task automatic add_line(input logic [TAGW-1:0] tag, input logic [COLW-1:0] colour,
                            input int x0, input int y0, input int x1, input int y1,
                            input logic mark_last);
        int     x, y, dx, dy, sx, sy, err, e2;
        logic   at_end;
        pixel_t p;
        x      = x0;
        y      = y0;
        dx     = (x1 > x0) ? x1 - x0 : x0 - x1;
        dy     = (y1 > y0) ? y0 - y1 : y1 - y0;  // minus |dy|
        sx     = (x1 < x0) ? -1 : 1;
        sy     = (y1 < y0) ? -1 : 1;
        err    = dx + dy;
        at_end = 1'b0;
        while (!at_end) begin
            at_end   = (x == x1) && (y == y1);
            p.x      = CORDW'(x);
            p.y      = CORDW'(y);
            p.colour = colour;
            p.tag    = tag;
            p.last   = mark_last && at_end;
            exp_q[tag].push_back(p);
            e2 = 2 * err;
            if (e2 >= dy) begin
                err = err + dy;
                x   = x + sx;
            end
            if (e2 <= dx) begin
                err = err + dx;
                y   = y + sy;
            end
        end
    endtask

    task automatic check_field(input string name, input int exp_v, input int got_v);
        if (exp_v != got_v) begin
            mismatches = mismatches + 1;
            $display("MISMATCH t=%0t %s expected %0d got %0d", $time, name, exp_v, got_v);
        end
    endtask

    task automatic fail(input string what);
        errors = errors + 1;
        $display("error at %0t: %s", $time, what);
    endtask

    always @(posedge clk) begin
        pixel_t e;
        rst_d  <= rst;
        rst_d2 <= rst_d;
        if ((rst_d || rst_d2) && (pix_valid !== 1'b0 || cmd_credit !== 1'b0))
            fail("pix_valid or cmd_credit high during or just after reset");
        if (!rst) begin
            // a credit returned in this cycle may already be spent by the host
            if (cmd_credit) begin
                returned = returned + 1;
                if (returned > spent) fail("more command credits returned than spent");
            end
            if (cmd_valid) begin
                spent     = spent + 1;
                cmds_open = cmds_open + 1;
                if (spent - returned > CMD_CREDITS) fail("host sent a command without a credit");
                if (cmd.op == OP_TRI) begin  // three edges, last on the closing one
                    add_line(cmd.tag, cmd.colour, coord(cmd.x0), coord(cmd.y0),
                             coord(cmd.x1), coord(cmd.y1), 1'b0);
                    add_line(cmd.tag, cmd.colour, coord(cmd.x1), coord(cmd.y1),
                             coord(cmd.x2), coord(cmd.y2), 1'b0);
                    add_line(cmd.tag, cmd.colour, coord(cmd.x2), coord(cmd.y2),
                             coord(cmd.x0), coord(cmd.y0), 1'b1);
                end else begin
                    add_line(cmd.tag, cmd.colour, coord(cmd.x0), coord(cmd.y0),
                             coord(cmd.x1), coord(cmd.y1), 1'b1);
                end
            end
            outstanding = outstanding + int'(pix_valid) - int'(pix_credit);
            if (outstanding > PIX_CREDITS) fail("more output pixels outstanding than credits");
            if (outstanding < 0) fail("sink returned a credit for no pixel");
            if (pix_valid) begin
                if (exp_q[pix.tag].size() == 0) begin
                    fail($sformatf("pixel for tag %0d with nothing expected", pix.tag));
                end else begin
                    e = exp_q[pix.tag].pop_front();
                    check_field("pix.x", coord(e.x), coord(pix.x));
                    check_field("pix.y", coord(e.y), coord(pix.y));
                    check_field("pix.colour", int'(e.colour), int'(pix.colour));
                    check_field("pix.last", int'(e.last), int'(pix.last));
                    if (e.last) cmds_open = cmds_open - 1;
                end
            end
            if (drain && !drained) begin  // everything should be back home
                for (int t = 0; t < 16; t++) begin
                    if (exp_q[t].size() != 0)
                        fail($sformatf("tag %0d missing %0d pixels", t, exp_q[t].size()));
                end
                if (returned != spent) fail("command credits not all returned");
                if (outstanding != 0) fail("output pixel credits not all returned");
                drained <= 1'b1;
            end
        end
    end

endmodule

//--- testbench/tb_draw.sv
// ################################################
// testbench for the outline rasterizer: random host,
// credit-returning sink, watchdog and checker
// ################################################
`timescale 1ns/1ns

module tb_draw;
    import draw_pkg::*;

    localparam int N_CMDS         = 60;
    localparam int TIMEOUT_CYCLES = N_CMDS * 3 * 33 * 7 + 2000;  // cmds x edges x pixels x cycles

    logic      clk        = 1'b0;
    logic      rst;
    logic      cmd_valid;
    draw_cmd_t cmd;
    logic      cmd_credit;
    logic      pix_valid;
    pixel_t    pix;
    logic      pix_credit = 1'b0;
    logic      drain;                          // end-of-run checks
    int        mismatches, errors, cmds_open;
    int        cyc      = 0;
    int        credits;                        // host command credits
    int        tag_sent [16] = '{default: 0};
    int        tag_done [16] = '{default: 0};
    int        due_q [$];                      // cycle when sink frees a slot
    int        last_due = 0;

    always #20 clk = ~clk;

    draw_top dut_i (
        .clk        (clk),
        .rst        (rst),
        .cmd_valid  (cmd_valid),
        .cmd        (cmd),
        .cmd_credit (cmd_credit),
        .pix_valid  (pix_valid),
        .pix        (pix),
        .pix_credit (pix_credit)
    );

    draw_checker chk_i (
        .clk (clk), .rst (rst), .cmd_valid (cmd_valid), .cmd (cmd),
        .cmd_credit (cmd_credit), .pix_valid (pix_valid), .pix (pix),
        .pix_credit (pix_credit), .drain (drain),
        .mismatches (mismatches), .errors (errors), .cmds_open (cmds_open)
    );

    // sink takes each pixel and schedules its credit, kept in order
    always @(posedge clk) begin
        int due;
        cyc = cyc + 1;
        if (!rst && pix_valid) begin
            due = cyc + int'($urandom_range(0, 5));
            if (due < last_due) due = last_due;
            last_due = due;
            due_q.push_back(due);
            if (pix.last) tag_done[pix.tag] = tag_done[pix.tag] + 1;  // tag free again
        end
    end

    always @(negedge clk) begin
        if (due_q.size() != 0 && due_q[0] <= cyc) begin
            void'(due_q.pop_front());
            pix_credit <= 1'b1;
        end else begin
            pix_credit <= 1'b0;
        end
    end

    function automatic logic signed [CORDW-1:0] rand_coord();
        return CORDW'(int'($urandom_range(0, 31)) - 16);  // -16..15, at most 32 pixels
    endfunction

    // one host cycle, picks up returned credits
    task automatic next_cycle();
        @(negedge clk);
        cmd_valid = 1'b0;
        if (cmd_credit) credits = credits + 1;
    endtask

    task automatic send_command(input int n);
        draw_cmd_t       c;
        logic [TAGW-1:0] t;
        t = TAGW'(n);  // tags cycle through 16 values
        while (credits == 0 || tag_sent[t] != tag_done[t]) next_cycle();
        c.op     = ($urandom_range(0, 1) == 1) ? OP_TRI : OP_LINE;
        c.tag    = t;
        c.colour = COLW'($urandom);
        c.x0     = rand_coord();
        c.y0     = rand_coord();
        c.x1     = rand_coord();
        c.y1     = rand_coord();
        c.x2     = rand_coord();
        c.y2     = rand_coord();
        if ($urandom_range(0, 7) == 0) begin  // degenerate first edge
            c.x1 = c.x0;
            c.y1 = c.y0;
        end
        cmd         = c;
        cmd_valid   = 1'b1;
        credits     = credits - 1;
        tag_sent[t] = tag_sent[t] + 1;
        next_cycle();
    endtask

    initial begin
        void'($urandom(55772));
        rst       = 1'b1;
        cmd_valid = 1'b0;
        cmd       = '0;
        drain     = 1'b0;
        credits   = CMD_CREDITS;
        repeat (10) @(negedge clk);
        rst = 1'b0;
        for (int n = 0; n < N_CMDS; n++) begin
            send_command(n);
            if ($urandom_range(0, 3) == 0) next_cycle();  // idle gap now and then
        end
        while (credits != CMD_CREDITS || cmds_open != 0 || due_q.size() != 0) next_cycle();
        drain = 1'b1;
        repeat (2) next_cycle();
        $display("mismatches: %0d  other errors: %0d", mismatches, errors);
        if (mismatches == 0 && errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    // watchdog
    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("timeout: run not finished after %0d cycles, %0d commands still open",
                 TIMEOUT_CYCLES, cmds_open);
        $display("mismatches: %0d  other errors: %0d", mismatches, errors);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

//--- list.f
rtl/draw_pkg.sv
rtl/draw_line.sv
rtl/draw_triangle.sv
rtl/cmd_dispatch.sv
rtl/pixel_merge.sv
rtl/draw_top.sv
testbench/draw_checker.sv
testbench/tb_draw.sv

//--- Makefile
# Verilator build and run of the outline rasterizer testbench

VERILATOR ?= verilator
TOP       ?= tb_draw
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FILELIST  ?= list.f
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q '^STATUS: PASS$$' $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
